/* flist.f */
+incdir+source
source/dcache_fsm_pkg.sv
source/dcache_op_pkg.sv
source/dcache_req_buf.sv
source/dcache_way.sv
source/dcache_lru.sv
source/dcache_fsm.sv
source/dcache_top.sv
bench/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

export_include_dirs:
  - source

sources:
  - source/dcache_fsm_pkg.sv
  - source/dcache_op_pkg.sv
  - source/dcache_req_buf.sv
  - source/dcache_way.sv
  - source/dcache_lru.sv
  - source/dcache_fsm.sv
  - source/dcache_top.sv
  - target: test
    files:
      - bench/dcache_tb.sv

/* bench/dcache_tb.sv */
// directed testbench for the data cache with a behavioral next-level memory, elaborated as the top
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_tb;

    localparam int          CLK_PERIOD     = 100;
    localparam int          MAX_REQS       = 60;
    localparam int          CYCLES_PER_REQ = 10;
    localparam int          MEM_WORDS      = 1024;
    localparam logic [31:0] MEM_OFS        = 32'h5a00_0000;  // memory init adds this to the address

    logic                     clk;
    logic                     rstn;
    logic                     valid;
    logic                     op;
    dcache_op_pkg::cacheop_e  opcode;
    logic [31:0]              addr;
    logic [31:0]              wdata;
    logic [3:0]               wstrb;
    dcache_op_pkg::req_kind_e kind;
    logic                     uncached;
    logic                     flush;
    logic                     ready;
    logic [31:0]              rdata;
    logic                     rdata_valid;
    logic                     mem_req;
    logic                     mem_wr;
    logic [31:0]              mem_addr;
    logic [31:0]              mem_wdata;
    logic [3:0]               mem_wstrb;
    logic                     mem_addr_ok;
    logic                     mem_data_ok;
    logic [`DC_LINE_W-1:0]    mem_rdata;

    logic [31:0] mem [MEM_WORDS];
    int          mem_reads;
    integer      seed = 24473;

    dcache_top dut_i (
        .clk, .rstn, .valid, .op, .opcode, .addr, .wdata, .wstrb, .kind, .uncached,
        .flush, .ready, .rdata, .rdata_valid,
        .mem_req, .mem_wr, .mem_addr, .mem_wdata, .mem_wstrb,
        .mem_addr_ok, .mem_data_ok, .mem_rdata
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] rule_word(input logic [31:0] a);
        return {a[31:2], 2'b00} + MEM_OFS;
    endfunction

    function automatic logic [31:0] merge_word(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  strb);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
        end
        return res;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // next-level memory model
    //////////////////////////////////////////////////////////////////////
    initial begin
        logic        rd_pending;
        logic [31:0] rd_addr;
        int          addr_wait;
        int          data_wait;
        rd_pending  = 1'b0;
        rd_addr     = '0;
        data_wait   = 0;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        mem_reads   = 0;
        for (int i = 0; i < MEM_WORDS; i++) mem[i] = rule_word(i * 4);
        addr_wait = $unsigned($random(seed)) % 4;
        forever begin
            @(posedge clk);
            if (mem_data_ok) rd_pending = 1'b0;  // line taken at this edge
            if (mem_req && mem_addr_ok) begin
                if (mem_wr) begin
                    mem[mem_addr[11:2]] = merge_word(mem[mem_addr[11:2]], mem_wdata, mem_wstrb);
                end else begin
                    mem_reads++;
                    rd_pending = 1'b1;
                    rd_addr    = mem_addr;
                    data_wait  = $unsigned($random(seed)) % 3;  // line 1..3 cycles later
                end
                addr_wait = $unsigned($random(seed)) % 4;
            end else if (mem_req && addr_wait > 0) begin
                addr_wait--;  // delay only runs while a request waits
            end
            @(negedge clk);
            mem_addr_ok = (addr_wait == 0) && !rd_pending;
            mem_data_ok = 1'b0;
            if (rd_pending) begin
                if (data_wait == 0) begin
                    mem_data_ok = 1'b1;
                    for (int w = 0; w < 4; w++) begin
                        mem_rdata[w*32 +: 32] = mem[rd_addr[11:4] * 4 + w];
                    end
                end else begin
                    data_wait--;
                end
            end
        end
    end

    initial begin
        #(MAX_REQS * CYCLES_PER_REQ * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in time");
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    //////////////////////////////////////////////////////////////////////
    // request and check helpers
    //////////////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("ERROR %s expected %h actual %h", name, exp, got);
            $display("TB FAILED");
            $fatal(1, "first error");
        end
    endtask

    // called at a falling edge and returns at the falling edge after acceptance
    task automatic send_request(input dcache_op_pkg::req_kind_e k, input logic [31:0] a,
                                input logic [31:0] d, input logic [3:0] s, input logic unc,
                                input logic is_op, input dcache_op_pkg::cacheop_e code);
        valid    = 1'b1;
        op       = is_op;
        opcode   = code;
        addr     = a;
        wdata    = d;
        wstrb    = s;
        kind     = k;
        uncached = unc;
        do @(posedge clk); while (!ready);
        @(negedge clk);
        valid = 1'b0;
        op    = 1'b0;
    endtask

    task automatic wait_done(output logic [31:0] data, output int n_valid, output int cycles);
        data    = '0;
        n_valid = 0;
        cycles  = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (rdata_valid) begin
                n_valid++;
                data = rdata;
            end
        end while (!ready);
        @(negedge clk);
    endtask

    task automatic check_load(input logic [31:0] a, input logic unc, input logic [31:0] exp,
                              input int new_reads, output int cycles);
        int          reads_before;
        int          n_valid;
        logic [31:0] data;
        reads_before = mem_reads;
        send_request(dcache_op_pkg::req_load, a, '0, '0, unc, 1'b0,
                     dcache_op_pkg::cop_index_init);
        wait_done(data, n_valid, cycles);
        check_value("rdata_valid count", 1, n_valid);
        check_value("rdata", exp, data);
        check_value("memory reads", new_reads, mem_reads - reads_before);
    endtask

    task automatic check_store(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
        logic [31:0] exp;
        logic [31:0] data;
        int          n_valid;
        int          cycles;
        exp = merge_word(mem[a[11:2]], d, s);
        send_request(dcache_op_pkg::req_store, a, d, s, 1'b0, 1'b0,
                     dcache_op_pkg::cop_index_init);
        wait_done(data, n_valid, cycles);
        check_value("rdata_valid count", 0, n_valid);
        check_value("memory word", exp, mem[a[11:2]]);
    endtask

    task automatic run_cacheop(input dcache_op_pkg::cacheop_e code, input logic [31:0] a);
        logic [31:0] data;
        int          n_valid;
        int          cycles;
        send_request(dcache_op_pkg::req_load, a, '0, '0, 1'b0, 1'b1, code);
        wait_done(data, n_valid, cycles);
        check_value("rdata_valid count", 0, n_valid);
        check_value("cacheop cycles", 1, cycles);  // acts in st_cacheop only
    endtask

    // load that sees flush rise in its lookup cycle and is dropped
    task automatic flushed_load(input logic [31:0] a);
        send_request(dcache_op_pkg::req_load, a, '0, '0, 1'b0, 1'b0,
                     dcache_op_pkg::cop_index_init);
        flush = 1'b1;  // lands in the lookup cycle
        @(posedge clk);
        check_value("mem_req", 0, mem_req);
        check_value("rdata_valid", 0, rdata_valid);
        check_value("ready", 1, ready);
        repeat (3) begin
            @(posedge clk);
            check_value("ready", 1, ready);
            check_value("rdata_valid", 0, rdata_valid);
            check_value("mem_req", 0, mem_req);
        end
        @(negedge clk);
        flush = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////
    task automatic test_miss_then_hit();
        int cycles;
        check_load(32'h010, 1'b0, rule_word(32'h010), 1, cycles);
        check_load(32'h018, 1'b0, rule_word(32'h018), 0, cycles);
        check_value("hit latency", 1, cycles);
    endtask

    task automatic test_write_through();
        int cycles;
        check_load(32'h020, 1'b0, rule_word(32'h020), 1, cycles);
        check_store(32'h024, 32'hdead_beef, 4'b0101);  // hit with partial strobes
        check_load(32'h024, 1'b0, merge_word(rule_word(32'h024), 32'hdead_beef, 4'b0101), 0,
                   cycles);
        check_store(32'h300, 32'h1234_5678, 4'b1111);  // line not in cache
        check_load(32'h300, 1'b0, 32'h1234_5678, 1, cycles);
    endtask

    task automatic test_lru();
        int cycles;
        check_load(32'h040, 1'b0, rule_word(32'h040), 1, cycles);  // A into way 0
        check_load(32'h140, 1'b0, rule_word(32'h140), 1, cycles);  // B into way 1
        check_load(32'h040, 1'b0, rule_word(32'h040), 0, cycles);
        check_load(32'h240, 1'b0, rule_word(32'h240), 1, cycles);  // C evicts B
        check_load(32'h040, 1'b0, rule_word(32'h040), 0, cycles);
        check_load(32'h140, 1'b0, rule_word(32'h140), 1, cycles);
    endtask

    task automatic test_uncached();
        int cycles;
        check_load(32'h080, 1'b0, rule_word(32'h080), 1, cycles);
        mem[32'h084 >> 2] = 32'h0bad_cafe;  // another master changes memory behind the cache
        check_load(32'h084, 1'b1, 32'h0bad_cafe, 1, cycles);
        check_load(32'h084, 1'b0, 32'h0bad_cafe, 1, cycles);  // copy was dropped
    endtask

    task automatic test_cacheops();
        int cycles;
        check_load(32'h0c0, 1'b0, rule_word(32'h0c0), 1, cycles);
        run_cacheop(dcache_op_pkg::cop_index_inval, 32'h0c0);  // way 0
        check_load(32'h0c0, 1'b0, rule_word(32'h0c0), 1, cycles);
        check_load(32'h0d0, 1'b0, rule_word(32'h0d0), 1, cycles);
        run_cacheop(dcache_op_pkg::cop_hit_inval, 32'h0d4);
        check_load(32'h0d0, 1'b0, rule_word(32'h0d0), 1, cycles);
        check_load(32'h0e0, 1'b0, rule_word(32'h0e0), 1, cycles);
        check_load(32'h1e0, 1'b0, rule_word(32'h1e0), 1, cycles);
        run_cacheop(dcache_op_pkg::cop_index_init, 32'h0e0);
        run_cacheop(dcache_op_pkg::cop_index_init, 32'h0e1);
        check_load(32'h0e0, 1'b0, rule_word(32'h0e0), 1, cycles);
        check_load(32'h1e0, 1'b0, rule_word(32'h1e0), 1, cycles);
    endtask

    task automatic test_flush();
        int cycles;
        check_load(32'h0f0, 1'b0, rule_word(32'h0f0), 1, cycles);
        flushed_load(32'h0f4);  // would hit
        flushed_load(32'h1f0);  // would miss
        check_load(32'h1f0, 1'b0, rule_word(32'h1f0), 1, cycles);
    endtask

    initial begin
        rstn     = 1'b0;
        valid    = 1'b0;
        op       = 1'b0;
        opcode   = dcache_op_pkg::cop_index_init;
        addr     = '0;
        wdata    = '0;
        wstrb    = '0;
        kind     = dcache_op_pkg::req_load;
        uncached = 1'b0;
        flush    = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        check_value("ready", 1, ready);
        check_value("mem_req", 0, mem_req);
        check_value("rdata_valid", 0, rdata_valid);
        test_miss_then_hit();
        test_write_through();
        test_lru();
        test_uncached();
        test_cacheops();
        test_flush();
        $display("TB PASSED");
        $finish;
    end

endmodule

/* source/dcache_top.sv */
// data cache top, wires request buffer, two ways, LRU and controller to pipeline and memory
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_top (
    input  logic                     clk,
    input  logic                     rstn,
    // pipeline side
    input  logic                     valid,
    input  logic                     op,
    input  dcache_op_pkg::cacheop_e   opcode,
    input  logic [31:0]              addr,
    input  logic [31:0]              wdata,
    input  logic [3:0]               wstrb,
    input  dcache_op_pkg::req_kind_e  kind,
    input  logic                     uncached,
    input  logic                     flush,
    output logic                     ready,
    output logic [31:0]              rdata,
    output logic                     rdata_valid,
    // memory side
    output logic                     mem_req,
    output logic                     mem_wr,
    output logic [31:0]              mem_addr,
    output logic [31:0]              mem_wdata,
    output logic [3:0]               mem_wstrb,
    input  logic                     mem_addr_ok,
    input  logic                     mem_data_ok,
    input  logic [`DC_LINE_W-1:0]    mem_rdata
);

    logic                     buf_we, buf_op, buf_uncached;
    dcache_op_pkg::cacheop_e  buf_opcode;
    dcache_op_pkg::req_kind_e buf_kind;
    logic [31:0]              buf_addr, buf_wdata;
    logic [3:0]               buf_wstrb;
    logic [1:0]               hit, data_we, line_fill, tag_clear, valid_clear;
    logic                     victim, lru_touch, lru_way, sel_way, sel_return;
    logic [`DC_LINE_W-1:0]    line0, line1, ret_line;
    logic [`DC_INDEX_W-1:0]   buf_index;
    logic [`DC_OFFSET_W-1:0]  buf_woff;

    assign buf_index = buf_addr[`DC_INDEX_LSB +: `DC_INDEX_W];
    assign buf_woff  = buf_addr[2 +: `DC_OFFSET_W];

    dcache_req_buf req_buf_i (
        .clk, .rstn, .we(buf_we),
        .in_op(op), .in_opcode(opcode), .in_addr(addr), .in_wdata(wdata),
        .in_wstrb(wstrb), .in_kind(kind), .in_uncached(uncached),
        .op(buf_op), .opcode(buf_opcode), .addr(buf_addr), .wdata(buf_wdata),
        .wstrb(buf_wstrb), .kind(buf_kind), .uncached(buf_uncached)
    );

    dcache_way way0_i (
        .clk, .rstn, .addr(buf_addr), .data_we(data_we[0]), .wdata(buf_wdata),
        .wstrb(buf_wstrb), .line_fill(line_fill[0]), .fill_line(mem_rdata),
        .tag_clear(tag_clear[0]), .valid_clear(valid_clear[0]),
        .clear_index(buf_index), .hit(hit[0]), .line(line0)
    );

    dcache_way way1_i (
        .clk, .rstn, .addr(buf_addr), .data_we(data_we[1]), .wdata(buf_wdata),
        .wstrb(buf_wstrb), .line_fill(line_fill[1]), .fill_line(mem_rdata),
        .tag_clear(tag_clear[1]), .valid_clear(valid_clear[1]),
        .clear_index(buf_index), .hit(hit[1]), .line(line1)
    );

    dcache_lru lru_i (
        .clk, .rstn, .index(buf_index), .touch(lru_touch),
        .touched_way(lru_way), .victim
    );

    dcache_fsm fsm_i (
        .clk, .rstn, .valid, .op, .flush,
        .buf_op, .buf_opcode, .buf_kind, .buf_uncached, .buf_addr,
        .hit, .victim, .mem_addr_ok, .mem_data_ok,
        .ready, .buf_we, .mem_req, .mem_wr,
        .data_we, .line_fill, .tag_clear, .valid_clear,
        .lru_touch, .lru_way, .sel_way, .sel_return, .rdata_valid
    );

    // memory sees the buffered request, stable until accepted
    assign mem_addr  = buf_addr;
    assign mem_wdata = buf_wdata;
    assign mem_wstrb = buf_wstrb;

    // return word from the hitting way or straight from the refill line
    assign ret_line = sel_return ? mem_rdata : (sel_way ? line1 : line0);
    assign rdata    = ret_line[buf_woff*32 +: 32];

endmodule

/* source/dcache_fsm.sv */
// data cache controller, sequences lookup, misses, write-through, cache ops and flush
`timescale 1ns/1ps

module dcache_fsm (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     valid,
    input  logic                     op,
    input  logic                     flush,
    input  logic                     buf_op,
    input  dcache_op_pkg::cacheop_e   buf_opcode,
    input  dcache_op_pkg::req_kind_e  buf_kind,
    input  logic                     buf_uncached,
    input  logic [31:0]              buf_addr,
    input  logic [1:0]               hit,
    input  logic                     victim,
    input  logic                     mem_addr_ok,
    input  logic                     mem_data_ok,
    output logic                     ready,
    output logic                     buf_we,
    output logic                     mem_req,
    output logic                     mem_wr,
    output logic [1:0]               data_we,
    output logic [1:0]               line_fill,
    output logic [1:0]               tag_clear,
    output logic [1:0]               valid_clear,
    output logic                     lru_touch,
    output logic                     lru_way,
    output logic                     sel_way,
    output logic                     sel_return,
    output logic                     rdata_valid
);

    dcache_fsm_pkg::dc_state_e state_q, state_d, state_acc;
    logic hit_way;
    logic miss;

    assign hit_way = hit[1];
    assign miss    = ~|hit || buf_uncached;  // uncached always goes to memory
    assign buf_we  = valid && ready;

    // where to go from any cycle with ready high
    assign state_acc = !valid ? dcache_fsm_pkg::st_idle :
                       op     ? dcache_fsm_pkg::st_cacheop : dcache_fsm_pkg::st_lookup;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= dcache_fsm_pkg::st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // next state and outputs
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        state_d     = state_q;
        ready       = 1'b0;
        mem_req     = 1'b0;
        mem_wr      = 1'b0;
        data_we     = 2'b00;
        line_fill   = 2'b00;
        tag_clear   = 2'b00;
        valid_clear = 2'b00;
        lru_touch   = 1'b0;
        lru_way     = hit_way;
        sel_way     = hit_way;
        sel_return  = 1'b0;
        rdata_valid = 1'b0;
        case (state_q)
            dcache_fsm_pkg::st_lookup: begin
                if (flush) begin  // abort, nothing written or requested
                    ready   = 1'b1;
                    state_d = dcache_fsm_pkg::st_flush;
                end else begin
                    if (buf_uncached) begin
                        valid_clear = hit;  // drop any cached copy
                    end
                    if (buf_kind == dcache_op_pkg::req_store) begin
                        mem_req = 1'b1;  // write-through, hit or not
                        mem_wr  = 1'b1;
                        if (!miss) begin
                            data_we[hit_way] = 1'b1;
                            lru_touch        = 1'b1;
                        end
                        if (mem_addr_ok) begin
                            ready   = 1'b1;
                            state_d = state_acc;
                        end else begin
                            state_d = miss ? dcache_fsm_pkg::st_miss_wr_req :
                                             dcache_fsm_pkg::st_hit_wr_req;
                        end
                    end else if (miss) begin
                        mem_req = 1'b1;
                        state_d = mem_addr_ok ? dcache_fsm_pkg::st_miss_rd_data :
                                                dcache_fsm_pkg::st_miss_rd_req;
                    end else begin  // read hit
                        rdata_valid = 1'b1;
                        lru_touch   = 1'b1;
                        ready       = 1'b1;
                        state_d     = state_acc;
                    end
                end
            end
            dcache_fsm_pkg::st_miss_rd_req: begin
                mem_req = 1'b1;
                if (mem_addr_ok) begin
                    state_d = dcache_fsm_pkg::st_miss_rd_data;
                end
            end
            dcache_fsm_pkg::st_miss_rd_data: begin
                if (mem_data_ok) begin
                    rdata_valid = 1'b1;
                    sel_return  = 1'b1;
                    ready       = 1'b1;
                    state_d     = state_acc;
                    if (!buf_uncached) begin  // fill the victim way
                        line_fill[victim] = 1'b1;
                        lru_touch         = 1'b1;
                        lru_way           = victim;
                    end
                end
            end
            dcache_fsm_pkg::st_miss_wr_req,
            dcache_fsm_pkg::st_hit_wr_req: begin
                mem_req = 1'b1;
                mem_wr  = 1'b1;
                if (mem_addr_ok) begin  // write done on address acceptance
                    ready   = 1'b1;
                    state_d = state_acc;
                end
            end
            dcache_fsm_pkg::st_cacheop: begin
                ready   = 1'b1;
                state_d = flush ? dcache_fsm_pkg::st_flush : state_acc;
                if (!flush && buf_op) begin
                    case (buf_opcode)
                        dcache_op_pkg::cop_index_init:  tag_clear[buf_addr[0]]   = 1'b1;
                        dcache_op_pkg::cop_index_inval: valid_clear[buf_addr[0]] = 1'b1;
                        dcache_op_pkg::cop_hit_inval:   valid_clear              = hit;
                        default:                        valid_clear              = 2'b00;
                    endcase
                end
            end
            dcache_fsm_pkg::st_flush: begin
                ready   = 1'b1;  // requests taken here are dropped
                state_d = flush ? dcache_fsm_pkg::st_flush : state_acc;
            end
            default: begin  // st_idle
                ready   = 1'b1;
                state_d = state_acc;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////
    a_hit_onehot: assert property (@(posedge clk) disable iff (!rstn)
        !(hit[0] && hit[1]));

    a_req_held: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_addr_ok |=> mem_req);

    a_flush_quiet: assert property (@(posedge clk) disable iff (!rstn)
        state_q == dcache_fsm_pkg::st_lookup && flush
        |-> !rdata_valid ##1 !rdata_valid && state_q == dcache_fsm_pkg::st_flush);

endmodule

/* source/dcache_lru.sv */
// per-set LRU bit for the two ways, names the replacement victim
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_lru (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [`DC_INDEX_W-1:0] index,
    input  logic                   touch,
    input  logic                   touched_way,
    output logic                   victim
);

    localparam int SETS = 1 << `DC_INDEX_W;

    logic [SETS-1:0] lru_q;  // 1 means way 1 is the older one

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (touch) begin
            lru_q[index] <= ~touched_way;  // point away from the way just used
        end
    end

    assign victim = lru_q[index];

endmodule

/* source/dcache_way.sv */
// one cache way, tag/valid/data arrays with combinational read and tag compare
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_way (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [31:0]            addr,
    input  logic                   data_we,
    input  logic [31:0]            wdata,
    input  logic [3:0]             wstrb,
    input  logic                   line_fill,
    input  logic [`DC_LINE_W-1:0]  fill_line,
    input  logic                   tag_clear,
    input  logic                   valid_clear,
    input  logic [`DC_INDEX_W-1:0] clear_index,
    output logic                   hit,
    output logic [`DC_LINE_W-1:0]  line
);

    localparam int SETS = 1 << `DC_INDEX_W;

    logic [`DC_TAG_W-1:0]    tag_mem  [SETS];
    logic [`DC_LINE_W-1:0]   data_mem [SETS];
    logic [SETS-1:0]         valid_q;
    logic [`DC_INDEX_W-1:0]  idx;
    logic [`DC_TAG_W-1:0]    tag;
    logic [`DC_OFFSET_W-1:0] woff;

    assign idx  = addr[`DC_INDEX_LSB +: `DC_INDEX_W];
    assign tag  = addr[`DC_TAG_LSB +: `DC_TAG_W];
    assign woff = addr[2 +: `DC_OFFSET_W];  // skip byte offset

    assign line = data_mem[idx];
    assign hit  = valid_q[idx] && (tag_mem[idx] == tag);

    // line storage, fill wins over a word write
    always_ff @(posedge clk) begin
        if (line_fill) begin
            data_mem[idx] <= fill_line;
        end else if (data_we) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    data_mem[idx][woff*32 + b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_fill) begin
            tag_mem[idx] <= tag;
        end else if (tag_clear) begin
            tag_mem[clear_index] <= '0;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (line_fill) begin
            valid_q[idx] <= 1'b1;
        end else if (tag_clear || valid_clear) begin
            valid_q[clear_index] <= 1'b0;  // index-init clears valid as well
        end
    end

    // the controller never fills and word-writes the same way at once
    a_no_fill_and_write: assert property (@(posedge clk) disable iff (!rstn)
        !(data_we && line_fill));

endmodule

/* source/dcache_req_buf.sv */
// request register, holds the accepted pipeline request through lookup and miss handling
`timescale 1ns/1ps

module dcache_req_buf (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    we,
    input  logic                    in_op,
    input  dcache_op_pkg::cacheop_e  in_opcode,
    input  logic [31:0]             in_addr,
    input  logic [31:0]             in_wdata,
    input  logic [3:0]              in_wstrb,
    input  dcache_op_pkg::req_kind_e in_kind,
    input  logic                    in_uncached,
    output logic                    op,
    output dcache_op_pkg::cacheop_e  opcode,
    output logic [31:0]             addr,
    output logic [31:0]             wdata,
    output logic [3:0]              wstrb,
    output dcache_op_pkg::req_kind_e kind,
    output logic                    uncached
);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            op       <= 1'b0;
            opcode   <= dcache_op_pkg::cop_index_init;
            addr     <= '0;
            wdata    <= '0;
            wstrb    <= '0;
            kind     <= dcache_op_pkg::req_load;
            uncached <= 1'b0;
        end else if (we) begin  // we already carries valid & ready
            op       <= in_op;
            opcode   <= in_opcode;
            addr     <= in_addr;
            wdata    <= in_wdata;
            wstrb    <= in_wstrb;
            kind     <= in_kind;
            uncached <= in_uncached;
        end
    end

endmodule

/* source/dcache_op_pkg.sv */
// request and cache-operation codes shared by the pipeline port, request buffer and FSM
package dcache_op_pkg;

    //////////////////////////////////////////////////////////////////////
    // pipeline request kind
    //////////////////////////////////////////////////////////////////////
    typedef enum logic {
        req_load,
        req_store
    } req_kind_e;

    //////////////////////////////////////////////////////////////////////
    // cache operations, valid on opcode when op is set
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        cop_index_init  = 2'd0,  // clear tag and valid of way addr[0]
        cop_index_inval = 2'd1,  // clear valid of way addr[0]
        cop_hit_inval   = 2'd2   // clear valid of the hitting way
    } cacheop_e;

endpackage

/* source/dcache_fsm_pkg.sv */
// controller state type for the data cache, referenced by scoped name from the FSM
package dcache_fsm_pkg;

    //////////////////////////////////////////////////////////////////////
    // main controller states
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        st_idle,
        st_lookup,        // tag compare, hit return, write hit update
        st_miss_rd_req,   // read address waiting for acceptance
        st_miss_rd_data,  // waiting for the line
        st_miss_wr_req,   // write-through of a missing line
        st_hit_wr_req,    // write-through of a hitting line
        st_cacheop,
        st_flush
    } dc_state_e;

endpackage

/* source/dcache_defines.svh */
// data cache geometry and address fields, include wherever arrays are sized or addresses sliced
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// 16 sets, 2 ways, 4 words per line
`define DC_INDEX_W    4
`define DC_OFFSET_W   2
`define DC_LINE_W     128

// address layout is tag | index | word offset | byte offset
`define DC_INDEX_LSB  (2 + `DC_OFFSET_W)
`define DC_TAG_LSB    (`DC_INDEX_LSB + `DC_INDEX_W)

// everything above the index, 24 bits with this geometry
`define DC_TAG_W      (32 - `DC_TAG_LSB)

`endif
